// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hci_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
source/hci_cfg_pkg.sv
source/hci_desc_pkg.sv
source/hci_queue_if.sv
source/hci_sync_fifo.sv
source/hci_ctrl_queues.sv
source/hci_csr_wb.sv
source/hci_xfer_engine.sv
source/hci_top.sv
test/hci_wb_props.sv
test/tb_hci_top.sv

// File: source/hci_cfg_pkg.sv
// Sizes, register map, queue bit positions and response codes shared by the HCI queue RTL
package hci_cfg_pkg;

  localparam int unsigned DataWidth  = 32;
  localparam int unsigned NumQueues  = 4;

  localparam int unsigned CmdDepth   = 8;
  localparam int unsigned TxDepth    = 16;
  localparam int unsigned RxDepth    = 16;
  localparam int unsigned RespDepth  = 8;
  localparam int unsigned CmdDepthW  = $clog2(CmdDepth + 1);
  localparam int unsigned TxDepthW   = $clog2(TxDepth + 1);
  localparam int unsigned RxDepthW   = $clog2(RxDepth + 1);
  localparam int unsigned RespDepthW = $clog2(RespDepth + 1);

  localparam int unsigned ThldWidth  = 8;
  localparam int unsigned MemWords   = 64;
  localparam int unsigned MemAdrW    = $clog2(MemWords);

  // Wishbone word addresses
  localparam int unsigned AdrWidth = 3;
  localparam logic [AdrWidth-1:0] AdrCmdPort     = 3'd0;
  localparam logic [AdrWidth-1:0] AdrXferData    = 3'd1;
  localparam logic [AdrWidth-1:0] AdrRespPort    = 3'd2;
  localparam logic [AdrWidth-1:0] AdrQueueThld   = 3'd3;
  localparam logic [AdrWidth-1:0] AdrQueueStatus = 3'd4;
  localparam logic [AdrWidth-1:0] AdrResetCtrl   = 3'd5;

  // Threshold byte lane per queue, also the 3-bit group index in the status word
  localparam int unsigned ThldCmdIdx  = 0;
  localparam int unsigned ThldRxIdx   = 1;
  localparam int unsigned ThldTxIdx   = 2;
  localparam int unsigned ThldRespIdx = 3;

  // Reset control bits
  localparam int unsigned ClrCmdBit  = 0;
  localparam int unsigned ClrTxBit   = 1;
  localparam int unsigned ClrRxBit   = 2;
  localparam int unsigned ClrRespBit = 3;

  localparam int unsigned StsRxDepthLsb   = 16;
  localparam int unsigned StsRespDepthLsb = 24;

  localparam logic [3:0] RespOk      = 4'd0;
  localparam logic [3:0] RespAddrErr = 4'd1;

  // Transfer engine FSM encoding
  localparam logic [1:0] EngIdle    = 2'd0;
  localparam logic [1:0] EngExec    = 2'd1;
  localparam logic [1:0] EngRespond = 2'd2;

endpackage

// File: source/hci_csr_wb.sv
// Wishbone classic register block giving software access to the HCI queues
module hci_csr_wb
  import hci_cfg_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [AdrWidth-1:0]            wb_adr_i,
  input  logic [DataWidth-1:0]           wb_dat_i,
  output logic [DataWidth-1:0]           wb_dat_o,
  output logic                           wb_ack_o,
  hci_queue_if.wr                        cmd_q,
  hci_queue_if.wr                        tx_q,
  hci_queue_if.rd                        rx_q,
  hci_queue_if.rd                        resp_q,
  output logic [NumQueues-1:0]           clr_o,
  output logic [NumQueues*ThldWidth-1:0] thld_o,
  input  logic [RxDepthW-1:0]            rx_depth_i,
  input  logic [RespDepthW-1:0]          resp_depth_i
);
  logic                 req;
  logic                 wr_req;
  logic                 rd_req;
  logic                 stall;
  logic [DataWidth-1:0] status;
  logic [DataWidth-1:0] rd_data;

  // A request is pending until its ack goes out
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_req = req & wb_we_i;
  assign rd_req = req & ~wb_we_i;

  // Queue transfers line up with the edge that raises ack
  assign cmd_q.wvalid  = wr_req & (wb_adr_i == AdrCmdPort);
  assign cmd_q.wdata   = wb_dat_i;
  assign tx_q.wvalid   = wr_req & (wb_adr_i == AdrXferData);
  assign tx_q.wdata    = wb_dat_i;
  assign rx_q.rready   = rd_req & (wb_adr_i == AdrXferData);
  assign resp_q.rready = rd_req & (wb_adr_i == AdrRespPort);
  assign clr_o = (wr_req && wb_adr_i == AdrResetCtrl) ? wb_dat_i[NumQueues-1:0] : '0;

  // Wait states while a target queue is full
  assign stall = (cmd_q.wvalid & ~cmd_q.wready) | (tx_q.wvalid & ~tx_q.wready);

  // Each group holds full, empty, threshold from its low bit up
  always_comb begin
    status = '0;
    status[3*ThldCmdIdx +: 3]  = {cmd_q.apch, cmd_q.empty, cmd_q.full};
    status[3*ThldRxIdx +: 3]   = {rx_q.apch, rx_q.empty, rx_q.full};
    status[3*ThldTxIdx +: 3]   = {tx_q.apch, tx_q.empty, tx_q.full};
    status[3*ThldRespIdx +: 3] = {resp_q.apch, resp_q.empty, resp_q.full};
    status[StsRxDepthLsb +: RxDepthW]     = rx_depth_i;
    status[StsRespDepthLsb +: RespDepthW] = resp_depth_i;
  end

  always_comb begin
    case (wb_adr_i)
      AdrXferData:    rd_data = rx_q.rvalid ? rx_q.rdata : '0;
      AdrRespPort:    rd_data = resp_q.rvalid ? resp_q.rdata : '0;
      AdrQueueThld:   rd_data = thld_o;
      AdrQueueStatus: rd_data = status;
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      thld_o   <= '0;
    end else begin
      wb_ack_o <= req & ~stall;
      if (wr_req && wb_adr_i == AdrQueueThld) begin
        thld_o <= wb_dat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

// File: source/hci_ctrl_queues.sv
// Command, transmit, receive and response queues with their empty and threshold flags
module hci_ctrl_queues
  import hci_cfg_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  hci_queue_if.queue                     cmd_q,
  hci_queue_if.queue                     tx_q,
  hci_queue_if.queue                     rx_q,
  hci_queue_if.queue                     resp_q,
  input  logic [NumQueues-1:0]           clr_i,
  input  logic [NumQueues*ThldWidth-1:0] thld_i,
  output logic [RxDepthW-1:0]            rx_depth_o,
  output logic [RespDepthW-1:0]          resp_depth_o
);
  logic [CmdDepthW-1:0] cmd_depth;
  logic [TxDepthW-1:0]  tx_depth;
  logic [CmdDepthW-1:0] cmd_free;
  logic [TxDepthW-1:0]  tx_free;
  logic [ThldWidth-1:0] cmd_thld;
  logic [ThldWidth-1:0] rx_thld;
  logic [ThldWidth-1:0] tx_thld;
  logic [ThldWidth-1:0] resp_thld;

  // True once count reaches 2^(thld+1), a zero threshold never fires
  function automatic logic pow2_reached(input logic [ThldWidth-1:0] thld,
                                        input logic [DataWidth-1:0] count);
    logic [DataWidth-1:0] level;
    level = (thld < ThldWidth'(DataWidth - 2)) ? (DataWidth'(1) << (thld + 1'b1)) : '1;
    return (thld != '0) && (count >= level);
  endfunction

  assign cmd_thld  = thld_i[ThldCmdIdx*ThldWidth +: ThldWidth];
  assign rx_thld   = thld_i[ThldRxIdx*ThldWidth +: ThldWidth];
  assign tx_thld   = thld_i[ThldTxIdx*ThldWidth +: ThldWidth];
  assign resp_thld = thld_i[ThldRespIdx*ThldWidth +: ThldWidth];

  assign cmd_q.empty  = (cmd_depth == '0);
  assign tx_q.empty   = (tx_depth == '0);
  assign rx_q.empty   = (rx_depth_o == '0);
  assign resp_q.empty = (resp_depth_o == '0);

  // Software side queues flag free room, engine side queues flag filled entries
  assign cmd_free    = CmdDepthW'(CmdDepth) - cmd_depth;
  assign tx_free     = TxDepthW'(TxDepth) - tx_depth;
  assign cmd_q.apch  = (cmd_thld != '0) && (ThldWidth'(cmd_free) >= cmd_thld);
  assign rx_q.apch   = pow2_reached(rx_thld, DataWidth'(rx_depth_o));
  assign tx_q.apch   = pow2_reached(tx_thld, DataWidth'(tx_free));
  assign resp_q.apch = (resp_thld != '0) && (ThldWidth'(resp_depth_o) >= resp_thld);

  hci_sync_fifo #(.DEPTH(CmdDepth)) u_cmd_fifo (
    .clk_i, .rst_n_i, .clr_i(clr_i[ClrCmdBit]),
    .wvalid_i(cmd_q.wvalid), .wready_o(cmd_q.wready), .wdata_i(cmd_q.wdata),
    .rvalid_o(cmd_q.rvalid), .rready_i(cmd_q.rready), .rdata_o(cmd_q.rdata),
    .depth_o(cmd_depth), .full_o(cmd_q.full)
  );

  hci_sync_fifo #(.DEPTH(TxDepth)) u_tx_fifo (
    .clk_i, .rst_n_i, .clr_i(clr_i[ClrTxBit]),
    .wvalid_i(tx_q.wvalid), .wready_o(tx_q.wready), .wdata_i(tx_q.wdata),
    .rvalid_o(tx_q.rvalid), .rready_i(tx_q.rready), .rdata_o(tx_q.rdata),
    .depth_o(tx_depth), .full_o(tx_q.full)
  );

  hci_sync_fifo #(.DEPTH(RxDepth)) u_rx_fifo (
    .clk_i, .rst_n_i, .clr_i(clr_i[ClrRxBit]),
    .wvalid_i(rx_q.wvalid), .wready_o(rx_q.wready), .wdata_i(rx_q.wdata),
    .rvalid_o(rx_q.rvalid), .rready_i(rx_q.rready), .rdata_o(rx_q.rdata),
    .depth_o(rx_depth_o), .full_o(rx_q.full)
  );

  hci_sync_fifo #(.DEPTH(RespDepth)) u_resp_fifo (
    .clk_i, .rst_n_i, .clr_i(clr_i[ClrRespBit]),
    .wvalid_i(resp_q.wvalid), .wready_o(resp_q.wready), .wdata_i(resp_q.wdata),
    .rvalid_o(resp_q.rvalid), .rready_i(resp_q.rready), .rdata_o(resp_q.rdata),
    .depth_o(resp_depth_o), .full_o(resp_q.full)
  );

endmodule

// File: source/hci_desc_pkg.sv
// Command and response descriptor layouts; imported by the transfer engine to decode queue words
package hci_desc_pkg;

  localparam logic [2:0] CmdAttrXfer = 3'd0;
  localparam logic [2:0] CmdAttrImm  = 3'd1;

  // Immediate data command, writes 16 bits into target memory
  typedef struct packed {
    logic [15:0] data;
    logic [5:0]  addr;
    logic [2:0]  rsvd;
    logic [3:0]  tid;
    logic [2:0]  attr;
  } hci_cmd_imm_t;

  // Regular transfer, moves len words between memory and the data queues
  typedef struct packed {
    logic [8:0] rsvd_hi;
    logic [6:0] len;
    logic [5:0] addr;
    logic [1:0] rsvd_lo;
    logic       rnw;
    logic [3:0] tid;
    logic [2:0] attr;
  } hci_cmd_xfer_t;

  // Both views keep tid and attr in the same bits
  typedef union packed {
    hci_cmd_imm_t  imm;
    hci_cmd_xfer_t xfer;
  } hci_cmd_u;

  typedef struct packed {
    logic [3:0]  status;
    logic [3:0]  tid;
    logic [7:0]  rsvd;
    logic [15:0] count;
  } hci_resp_t;

endpackage

// File: source/hci_queue_if.sv
// One HCI queue as seen by its producer, its consumer and the queue block itself
interface hci_queue_if
  import hci_cfg_pkg::*;
();
  logic                 wvalid;
  logic                 wready;
  logic [DataWidth-1:0] wdata;
  logic                 rvalid;
  logic                 rready;
  logic [DataWidth-1:0] rdata;
  logic                 full;
  logic                 empty;
  logic                 apch;

  // Producer side
  modport wr (output wvalid, output wdata, input wready, input full, input empty, input apch);

  // Consumer side
  modport rd (output rready, input rvalid, input rdata, input full, input empty, input apch);

  modport queue (
    input  wvalid, input  wdata, output wready,
    output rvalid, output rdata, input  rready,
    output full, output empty, output apch
  );
endinterface

// File: source/hci_sync_fifo.sv
// Synchronous valid/ready FIFO with clear and occupancy count, one per HCI queue
module hci_sync_fifo
  import hci_cfg_pkg::*;
#(
  parameter int unsigned DEPTH = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clr_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [DataWidth-1:0]       wdata_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [DataWidth-1:0]       rdata_o,
  output logic [$clog2(DEPTH+1)-1:0] depth_o,
  output logic                       full_o
);
  logic [DataWidth-1:0]     mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wptr_q;
  logic [$clog2(DEPTH)-1:0] rptr_q;
  logic                     push;
  logic                     pop;

  function automatic logic [$clog2(DEPTH)-1:0] ptr_inc(input logic [$clog2(DEPTH)-1:0] ptr);
    return (ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o   = (depth_o == ($clog2(DEPTH+1))'(DEPTH));
  assign wready_o = ~full_o;
  assign rvalid_o = (depth_o != '0);
  // Head entry straight from storage, a new word shows up the cycle after its push
  assign rdata_o  = mem[rptr_q];
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      depth_o <= '0;
    end else if (clr_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      depth_o <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      if (push && !pop) begin
        depth_o <= depth_o + 1'b1;
      end else if (pop && !push) begin
        depth_o <= depth_o - 1'b1;
      end
    end
  end

endmodule

// File: source/hci_top.sv
// Top level of the HCI queue subsystem, the Wishbone slave and interrupt seen by the testbench
module hci_top
  import hci_cfg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [AdrWidth-1:0]  wb_adr_i,
  input  logic [DataWidth-1:0] wb_dat_i,
  output logic [DataWidth-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 irq_o
);
  logic [NumQueues-1:0]           clr;
  logic [NumQueues*ThldWidth-1:0] thld;
  logic [RxDepthW-1:0]            rx_depth;
  logic [RespDepthW-1:0]          resp_depth;

  hci_queue_if cmd_q ();
  hci_queue_if tx_q ();
  hci_queue_if rx_q ();
  hci_queue_if resp_q ();

  hci_csr_wb u_csr (
    .clk_i, .rst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .cmd_q, .tx_q, .rx_q, .resp_q,
    .clr_o(clr), .thld_o(thld), .rx_depth_i(rx_depth), .resp_depth_i(resp_depth)
  );

  hci_ctrl_queues u_queues (
    .clk_i, .rst_n_i,
    .cmd_q, .tx_q, .rx_q, .resp_q,
    .clr_i(clr), .thld_i(thld), .rx_depth_o(rx_depth), .resp_depth_o(resp_depth)
  );

  hci_xfer_engine u_engine (
    .clk_i, .rst_n_i,
    .cmd_q, .tx_q, .rx_q, .resp_q
  );

  // Interrupt follows the response threshold flag
  assign irq_o = resp_q.apch;

endmodule

// File: source/hci_xfer_engine.sv
// Transfer engine standing in for the I3C bus, runs queued commands against a local memory
module hci_xfer_engine
  import hci_cfg_pkg::*;
  import hci_desc_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  hci_queue_if.rd cmd_q,
  hci_queue_if.rd tx_q,
  hci_queue_if.wr rx_q,
  hci_queue_if.wr resp_q
);
  logic [DataWidth-1:0] mem [MemWords];
  logic [1:0]           state_q;
  logic [MemAdrW-1:0]   ptr_q;
  logic [6:0]           moved_q;
  hci_cmd_u             in_cmd;
  hci_cmd_u             cur_cmd;
  hci_resp_t            resp;
  logic                 is_imm;
  logic                 reject;
  logic                 done;
  logic                 moving;
  logic                 move;

  assign in_cmd = cmd_q.rdata;
  assign is_imm = (cur_cmd.imm.attr == CmdAttrImm);
  // Unknown attributes are refused like an out of range transfer
  assign reject = ~is_imm & ((cur_cmd.xfer.attr != CmdAttrXfer) |
                  (({2'b00, cur_cmd.xfer.addr} + {1'b0, cur_cmd.xfer.len}) > 8'(MemWords)));
  assign done   = is_imm | reject | (moved_q == cur_cmd.xfer.len);
  assign moving = (state_q == EngExec) & ~done;

  assign cmd_q.rready = (state_q == EngIdle);
  assign tx_q.rready  = moving & ~cur_cmd.xfer.rnw;
  assign rx_q.wvalid  = moving & cur_cmd.xfer.rnw;
  assign rx_q.wdata   = mem[ptr_q];
  assign move = (tx_q.rready & tx_q.rvalid) | (rx_q.wvalid & rx_q.wready);

  always_comb begin
    resp        = '0;
    resp.tid    = cur_cmd.xfer.tid;
    resp.status = reject ? RespAddrErr : RespOk;
    resp.count  = is_imm ? 16'd1 : 16'(moved_q);
  end

  assign resp_q.wvalid = (state_q == EngRespond);
  assign resp_q.wdata  = resp;

  always_ff @(posedge clk_i) begin
    if (cmd_q.rvalid && cmd_q.rready) begin
      cur_cmd <= in_cmd;
    end
    if (state_q == EngExec && is_imm) begin
      mem[cur_cmd.imm.addr] <= DataWidth'(cur_cmd.imm.data);
    end else if (tx_q.rready && tx_q.rvalid) begin
      mem[ptr_q] <= tx_q.rdata;
    end
  end

  // Exec finishes one cycle after the last word, so a transfer costs len + 2 cycles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= EngIdle;
      ptr_q   <= '0;
      moved_q <= '0;
    end else begin
      case (state_q)
        EngIdle: begin
          if (cmd_q.rvalid) begin
            state_q <= EngExec;
            ptr_q   <= in_cmd.xfer.addr;
            moved_q <= '0;
          end
        end
        EngExec: begin
          if (done) begin
            state_q <= EngRespond;
          end else if (move) begin
            ptr_q   <= ptr_q + 1'b1;
            moved_q <= moved_q + 1'b1;
          end
        end
        EngRespond: begin
          if (resp_q.wready) begin
            state_q <= EngIdle;
          end
        end
        default: state_q <= EngIdle;
      endcase
    end
  end

endmodule

// File: test/hci_wb_props.sv
// Wishbone handshake assertions, bound into every hci_csr_wb instance
module hci_wb_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i
);
  int unsigned fail_count = 0;

  // Ack answers a request that was present on the edge before
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
  else begin
    fail_count++;
    $error("ack rose without an active cycle and strobe");
  end

  // Single cycle pulse
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
  else begin
    fail_count++;
    $error("ack held high for two cycles");
  end

  ack_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_ack_i)
  else begin
    fail_count++;
    $error("ack high while reset is asserted");
  end

endmodule

bind hci_csr_wb hci_wb_props u_props (
  .clk_i, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_ack_i(wb_ack_o)
);

// File: test/tb_hci_top.sv
// Table-driven testbench for hci_top that runs Wishbone accesses and checks queue and engine behavior
module tb_hci_top
  import hci_cfg_pkg::*;
();
  localparam int OpWrite    = 0;
  localparam int OpRead     = 1;
  localparam int OpWaitResp = 2;
  localparam int AckTimeout = 50;
  localparam int PollLimit  = 60;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [AdrWidth-1:0]  wb_adr_i;
  logic [DataWidth-1:0] wb_dat_i;
  logic [DataWidth-1:0] wb_dat_o;
  logic                 wb_ack_o;
  logic                 irq_o;

  // Stimulus table with one entry per row in each queue
  string                name_q[$];
  int                   op_q[$];
  logic [AdrWidth-1:0]  adr_q[$];
  logic [DataWidth-1:0] data_q[$];
  logic [DataWidth-1:0] exp_q[$];
  int                   num_rows = 0;
  int                   mismatches = 0;
  int                   failures = 0;
  int                   seed;
  logic [DataWidth-1:0] payload[5];

  hci_top u_hci_top (
    .clk_i, .rst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Command words keep attr in bits 2:0, tid in 6:3, rnw in 7 and addr in 15:10
  function automatic logic [31:0] imm_cmd(input logic [3:0] tid, input logic [5:0] adr,
                                          input logic [15:0] data);
    return {data, adr, 3'b000, tid, 3'd1};
  endfunction

  function automatic logic [31:0] xfer_cmd(input logic rnw, input logic [3:0] tid,
                                           input logic [5:0] adr, input logic [6:0] len);
    return {9'd0, len, adr, 2'b00, rnw, tid, 3'd0};
  endfunction

  function automatic logic [31:0] resp_word(input logic [3:0] status, input logic [3:0] tid,
                                            input logic [15:0] count);
    return {status, tid, 8'h00, count};
  endfunction

  task automatic add_row(input string name, input int op, input logic [AdrWidth-1:0] adr,
                         input logic [31:0] data, input logic [31:0] exp);
    name_q.push_back(name);
    op_q.push_back(op);
    adr_q.push_back(adr);
    data_q.push_back(data);
    exp_q.push_back(exp);
    num_rows++;
  endtask

  // One Wishbone classic access with the request held until ack or timeout
  task automatic wb_transfer(input string name, input logic we, input logic [AdrWidth-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wb_ack_o && waited < AckTimeout);
    rdata = wb_dat_o;
    if (!wb_ack_o) begin
      $display("%s: no Wishbone ack within %0d cycles", name, AckTimeout);
      failures++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // Poll the status word until the response depth reaches count, then check the interrupt
  task automatic wait_responses(input string name, input int count, input logic irq_exp);
    logic [31:0] sts;
    int polls;
    polls = 0;
    sts = '0;
    do begin
      wb_transfer(name, 1'b0, AdrQueueStatus, '0, sts);
      polls++;
    end while (int'(sts[StsRespDepthLsb +: RespDepthW]) < count && polls < PollLimit);
    if (int'(sts[StsRespDepthLsb +: RespDepthW]) < count) begin
      $display("%s: response never came after %0d status polls", name, PollLimit);
      failures++;
    end else if (irq_o !== irq_exp) begin
      $display("mismatch %s: expected irq %b, actual %b", name, irq_exp, irq_o);
      mismatches++;
    end
  endtask

  task automatic build_table();
    add_row("reset_status", OpRead, AdrQueueStatus, '0, 32'h0000_0492);
    add_row("imm_cmd", OpWrite, AdrCmdPort, imm_cmd(4'd1, 6'd5, payload[4][15:0]), '0);
    add_row("imm_read_cmd", OpWrite, AdrCmdPort, xfer_cmd(1'b1, 4'd2, 6'd5, 7'd1), '0);
    add_row("imm_wait", OpWaitResp, '0, 32'd2, 32'd0);
    add_row("imm_resp", OpRead, AdrRespPort, '0, resp_word(RespOk, 4'd1, 16'd1));
    add_row("imm_read_resp", OpRead, AdrRespPort, '0, resp_word(RespOk, 4'd2, 16'd1));
    add_row("imm_rx_data", OpRead, AdrXferData, '0, {16'h0000, payload[4][15:0]});
    for (int k = 0; k < 4; k++) begin
      add_row("tx_data", OpWrite, AdrXferData, payload[k], '0);
    end
    add_row("wr_cmd", OpWrite, AdrCmdPort, xfer_cmd(1'b0, 4'd3, 6'd10, 7'd4), '0);
    add_row("rd_cmd", OpWrite, AdrCmdPort, xfer_cmd(1'b1, 4'd4, 6'd10, 7'd4), '0);
    add_row("xfer_wait", OpWaitResp, '0, 32'd2, 32'd0);
    add_row("wr_resp", OpRead, AdrRespPort, '0, resp_word(RespOk, 4'd3, 16'd4));
    add_row("rd_resp", OpRead, AdrRespPort, '0, resp_word(RespOk, 4'd4, 16'd4));
    for (int k = 0; k < 4; k++) begin
      add_row("rx_data", OpRead, AdrXferData, '0, payload[k]);
    end
    // 62 + 4 runs past the end of target memory
    add_row("oob_cmd", OpWrite, AdrCmdPort, xfer_cmd(1'b1, 4'd5, 6'd62, 7'd4), '0);
    add_row("oob_wait", OpWaitResp, '0, 32'd1, 32'd0);
    add_row("oob_resp", OpRead, AdrRespPort, '0, resp_word(RespAddrErr, 4'd5, 16'd0));
    add_row("oob_status", OpRead, AdrQueueStatus, '0, 32'h0000_0492);
    // Response threshold 2, rx threshold 1 so the rx flag needs 4 words
    add_row("set_thld", OpWrite, AdrQueueThld, 32'h0200_0100, '0);
    add_row("thld_imm_cmd", OpWrite, AdrCmdPort, imm_cmd(4'd6, 6'd20, 16'h1234), '0);
    add_row("thld_one_resp", OpWaitResp, '0, 32'd1, 32'd0);
    add_row("thld_one_status", OpRead, AdrQueueStatus, '0, 32'h0100_0092);
    add_row("thld_rx_cmd", OpWrite, AdrCmdPort, xfer_cmd(1'b1, 4'd7, 6'd10, 7'd4), '0);
    add_row("thld_two_resp", OpWaitResp, '0, 32'd2, 32'd1);
    add_row("thld_two_status", OpRead, AdrQueueStatus, '0, 32'h0204_08a2);
    // Three rx words left sit below the rx flag level
    add_row("thld_rx_pop", OpRead, AdrXferData, '0, payload[0]);
    add_row("thld_three_status", OpRead, AdrQueueStatus, '0, 32'h0203_0882);
    add_row("clear_rx_resp", OpWrite, AdrResetCtrl, 32'h0000_000c, '0);
    add_row("clear_status", OpRead, AdrQueueStatus, '0, 32'h0000_0492);
    add_row("clear_rx_pop", OpRead, AdrXferData, '0, '0);
    add_row("clear_resp_pop", OpRead, AdrRespPort, '0, '0);
  endtask

  initial begin
    wait (rst_n_i === 1'b1);
    repeat (num_rows * 200) @(posedge clk_i);
    $display("timeout: the %0d table rows did not finish in time", num_rows);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    seed = 41;
    for (int k = 0; k < 5; k++) begin
      payload[k] = $random(seed);
    end
    build_table();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (irq_o !== 1'b0) begin
      $display("mismatch reset_irq: expected 0, actual %b", irq_o);
      mismatches++;
    end
    for (int i = 0; i < num_rows; i++) begin
      case (op_q[i])
        OpWrite: wb_transfer(name_q[i], 1'b1, adr_q[i], data_q[i], rdata);
        OpRead: begin
          wb_transfer(name_q[i], 1'b0, adr_q[i], '0, rdata);
          if (rdata !== exp_q[i]) begin
            $display("mismatch %s: expected %h, actual %h", name_q[i], exp_q[i], rdata);
            mismatches++;
          end
        end
        default: wait_responses(name_q[i], int'(data_q[i]), exp_q[i][0]);
      endcase
    end
    // Wishbone protocol violations seen by the bound assertions
    failures += int'(u_hci_top.u_csr.u_props.fail_count);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
